// File: design/soc_bus_pkg.sv
// widths, vector typedefs, address map, initiator indices and state enums for the soc bus
package soc_bus_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [DATA_W/8-1:0] strb_t; // one enable per byte lane

  // initiators
  localparam int N_INIT = 3;

  typedef logic [1:0] init_idx_t;

  localparam init_idx_t INIT_CLUSTER = 2'd0;
  localparam init_idx_t INIT_HOST    = 2'd1;
  localparam init_idx_t INIT_DEBUG   = 2'd2;

  // decoded target of a request
  typedef enum logic [1:0] {
    TGT_L2,
    TGT_DEBUG,
    TGT_EXT,
    TGT_NONE
  } tgt_t;

  // L2 scratchpad window
  localparam addr_t       L2_BASE  = 32'h1C00_0000;
  localparam int unsigned L2_BYTES = 4096;
  localparam int unsigned L2_WORDS = L2_BYTES / (DATA_W / 8);

  typedef logic [$clog2(L2_WORDS)-1:0] l2_idx_t;

  // debug register window
  localparam addr_t       DEBUG_BASE  = 32'h1A11_0000;
  localparam int unsigned DEBUG_BYTES = 256;

  // external port takes everything from here up to the top of the address space
  localparam addr_t EXT_BASE = DEBUG_BASE + addr_t'(DEBUG_BYTES);

  localparam data_t DEBUG_ID = 32'h50C0_B001; // read-only id word

  // arbiter FSM
  typedef enum logic {
    ARB_IDLE,
    ARB_BUSY
  } arb_state_t;

endpackage

// File: design/bus_if.sv
// bus_if interface: single-word request/response channel with mst, slv and mon modports
`timescale 1ns/1ps

interface bus_if;
  import soc_bus_pkg::*;

  // request
  logic  req_valid;
  logic  req_ready;
  addr_t addr;
  logic  write;
  data_t wdata;
  strb_t strb;

  // response, one pulse per accepted request
  logic  rsp_valid;
  data_t rdata;
  logic  err;

  modport mst (
    output req_valid, addr, write, wdata, strb,
    input  req_ready, rsp_valid, rdata, err
  );

  modport slv (
    input  req_valid, addr, write, wdata, strb,
    output req_ready, rsp_valid, rdata, err
  );

  modport mon (
    input req_valid, req_ready, addr, write, wdata, strb,
    input rsp_valid, rdata, err
  );

endinterface

// File: design/bus_arbiter.sv
// bus_arbiter module: round-robin grant of three initiators onto the shared bus, response return
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                             clk,
  input  logic                             arst_n,
  // initiator side
  input  logic [soc_bus_pkg::N_INIT-1:0]   req_valid,
  input  soc_bus_pkg::addr_t               addr [soc_bus_pkg::N_INIT],
  input  logic [soc_bus_pkg::N_INIT-1:0]   write,
  input  soc_bus_pkg::data_t               wdata [soc_bus_pkg::N_INIT],
  input  soc_bus_pkg::strb_t               strb [soc_bus_pkg::N_INIT],
  output logic [soc_bus_pkg::N_INIT-1:0]   req_ready,
  output logic [soc_bus_pkg::N_INIT-1:0]   rsp_valid,
  output soc_bus_pkg::data_t               rdata [soc_bus_pkg::N_INIT],
  output logic [soc_bus_pkg::N_INIT-1:0]   err,
  // shared bus
  bus_if.mst                               bus
);
  import soc_bus_pkg::*;

  arb_state_t state_q;
  init_idx_t  grant_q;  // last granted, also owner of the pending response
  init_idx_t  pick;
  logic       found;

  // round-robin search, starting after the last grant
  always_comb begin
    int cand;
    pick  = grant_q;
    found = 1'b0;
    for (int k = 1; k <= N_INIT; k++) begin
      cand = (int'(grant_q) + k) % N_INIT;
      if (!found && req_valid[cand]) begin
        pick  = init_idx_t'(cand);
        found = 1'b1;
      end
    end
  end

  // winner's request onto the shared bus, only while idle
  assign bus.req_valid = (state_q == ARB_IDLE) && found;
  assign bus.addr      = addr[pick];
  assign bus.write     = write[pick];
  assign bus.wdata     = wdata[pick];
  assign bus.strb      = strb[pick];

  always_comb begin
    for (int i = 0; i < N_INIT; i++) begin
      req_ready[i] = (state_q == ARB_IDLE) && found && (pick == init_idx_t'(i))
                     && bus.req_ready;
      rsp_valid[i] = (state_q == ARB_BUSY) && bus.rsp_valid
                     && (grant_q == init_idx_t'(i));
      // others see zeros
      rdata[i]     = (rsp_valid[i]) ? bus.rdata : '0;
      err[i]       = rsp_valid[i] && bus.err;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= ARB_IDLE;
      grant_q <= INIT_DEBUG; // so the cluster is searched first
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (bus.req_valid && bus.req_ready) begin
            grant_q <= pick;
            state_q <= ARB_BUSY;
          end
        end
        ARB_BUSY: begin
          if (bus.rsp_valid) begin
            state_q <= ARB_IDLE; // next grant one cycle later at the earliest
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

endmodule

// File: design/addr_decoder.sv
// addr_decoder module: address rule matching, target select, response mux, decode-error responder
`timescale 1ns/1ps

module addr_decoder (
  input  logic clk,
  input  logic arst_n,
  bus_if.slv   up,
  bus_if.mst   l2,
  bus_if.mst   dbg,
  bus_if.mst   ext
);
  import soc_bus_pkg::*;

  tgt_t tgt;        // decode of the current request
  tgt_t sel_q;      // target of the transfer in flight
  logic none_rsp_q; // error pulse for unmapped addresses

  // rule table, checked in priority order
  always_comb begin
    if (up.addr >= L2_BASE && up.addr < L2_BASE + addr_t'(L2_BYTES)) begin
      tgt = TGT_L2;
    end else if (up.addr >= DEBUG_BASE && up.addr < EXT_BASE) begin
      tgt = TGT_DEBUG;
    end else if (up.addr >= EXT_BASE) begin
      tgt = TGT_EXT;  // runs up to 0xFFFF_FFFF
    end else begin
      tgt = TGT_NONE;
    end
  end

  // request fields fan out, valid goes to the match only
  assign l2.req_valid  = up.req_valid && (tgt == TGT_L2);
  assign dbg.req_valid = up.req_valid && (tgt == TGT_DEBUG);
  assign ext.req_valid = up.req_valid && (tgt == TGT_EXT);

  assign l2.addr   = up.addr;
  assign l2.write  = up.write;
  assign l2.wdata  = up.wdata;
  assign l2.strb   = up.strb;
  assign dbg.addr  = up.addr;
  assign dbg.write = up.write;
  assign dbg.wdata = up.wdata;
  assign dbg.strb  = up.strb;
  assign ext.addr  = up.addr;
  assign ext.write = up.write;
  assign ext.wdata = up.wdata;
  assign ext.strb  = up.strb;

  always_comb begin
    case (tgt)
      TGT_L2:    up.req_ready = l2.req_ready;
      TGT_DEBUG: up.req_ready = dbg.req_ready;
      TGT_EXT:   up.req_ready = ext.req_ready; // external may stall
      default:   up.req_ready = 1'b1;          // unmapped, accept at once
    endcase
  end

  // response from whoever took the last transfer
  always_comb begin
    case (sel_q)
      TGT_L2:    {up.rsp_valid, up.rdata, up.err} = {l2.rsp_valid, l2.rdata, l2.err};
      TGT_DEBUG: {up.rsp_valid, up.rdata, up.err} = {dbg.rsp_valid, dbg.rdata, dbg.err};
      TGT_EXT:   {up.rsp_valid, up.rdata, up.err} = {ext.rsp_valid, ext.rdata, ext.err};
      default:   {up.rsp_valid, up.rdata, up.err} = {none_rsp_q, DATA_W'(0), 1'b1};
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sel_q      <= TGT_NONE;
      none_rsp_q <= 1'b0;
    end else begin
      none_rsp_q <= up.req_valid && up.req_ready && (tgt == TGT_NONE);
      if (up.req_valid && up.req_ready) begin
        sel_q <= tgt;
      end
    end
  end

endmodule

// File: design/l2_mem.sv
// l2_mem module: word-addressed L2 scratchpad with byte strobes and one-cycle response
`timescale 1ns/1ps

module l2_mem (
  input  logic clk,
  input  logic arst_n,
  bus_if.slv   bus
);
  import soc_bus_pkg::*;

  data_t   mem [L2_WORDS];
  addr_t   offs;
  l2_idx_t idx;
  logic    rsp_valid_q;
  data_t   rdata_q;

  assign offs = bus.addr - L2_BASE;
  assign idx  = offs[2 +: $bits(l2_idx_t)]; // word index, byte offset dropped

  assign bus.req_ready = 1'b1; // never stalls

  // strobed write, only enabled lanes change
  always_ff @(posedge clk) begin
    if (bus.req_valid && bus.write) begin
      for (int b = 0; b < DATA_W / 8; b++) begin
        if (bus.strb[b]) begin
          mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.req_valid) begin
      rdata_q <= (bus.write) ? '0 : mem[idx]; // writes answer with zero
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= bus.req_valid;
    end
  end

  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rdata     = rdata_q;
  assign bus.err       = 1'b0;

endmodule

// File: design/debug_regs.sv
// debug_regs module: four strobed scratch registers, read-only id word and error on other offsets
`timescale 1ns/1ps

module debug_regs (
  input  logic clk,
  input  logic arst_n,
  bus_if.slv   bus
);
  import soc_bus_pkg::*;

  data_t                           scratch [4];
  logic [$clog2(DEBUG_BYTES)-1:0]  offs;
  logic                            is_scratch;
  logic                            is_id;
  logic                            rsp_valid_q;
  data_t                           rdata_q;
  logic                            err_q;

  assign offs       = bus.addr[$clog2(DEBUG_BYTES)-1:0]; // base is window aligned
  assign is_scratch = (offs[$bits(offs)-1:4] == '0) && (offs[1:0] == 2'b00);
  assign is_id      = (offs == 8'h10);

  assign bus.req_ready = 1'b1;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int r = 0; r < 4; r++) begin
        scratch[r] <= '0;
      end
      rsp_valid_q <= 1'b0;
      rdata_q     <= '0;
      err_q       <= 1'b0;
    end else begin
      rsp_valid_q <= bus.req_valid;
      if (bus.req_valid) begin
        rdata_q <= '0;
        err_q   <= 1'b0;
        if (is_scratch) begin
          if (bus.write) begin
            for (int b = 0; b < DATA_W / 8; b++) begin
              if (bus.strb[b]) scratch[offs[3:2]][8*b +: 8] <= bus.wdata[8*b +: 8];
            end
          end else begin
            rdata_q <= scratch[offs[3:2]];
          end
        end else if (is_id) begin
          if (!bus.write) rdata_q <= DEBUG_ID; // write silently dropped
        end else begin
          err_q <= 1'b1; // hole in the window
        end
      end
    end
  end

  assign bus.rsp_valid = rsp_valid_q;
  assign bus.rdata     = rdata_q;
  assign bus.err       = err_q;

endmodule

// File: design/soc_bus.sv
// soc_bus top module: initiator and external ports, bus instances, arbiter, decoder, L2, debug
`timescale 1ns/1ps

module soc_bus (
  input  logic                             clk,
  input  logic                             arst_n,
  // initiators, indexed by initiator number
  input  logic [soc_bus_pkg::N_INIT-1:0]   init_req_valid,
  input  soc_bus_pkg::addr_t               init_addr [soc_bus_pkg::N_INIT],
  input  logic [soc_bus_pkg::N_INIT-1:0]   init_write,
  input  soc_bus_pkg::data_t               init_wdata [soc_bus_pkg::N_INIT],
  input  soc_bus_pkg::strb_t               init_strb [soc_bus_pkg::N_INIT],
  output logic [soc_bus_pkg::N_INIT-1:0]   init_req_ready,
  output logic [soc_bus_pkg::N_INIT-1:0]   init_rsp_valid,
  output soc_bus_pkg::data_t               init_rdata [soc_bus_pkg::N_INIT],
  output logic [soc_bus_pkg::N_INIT-1:0]   init_err,
  // external target
  output logic                             ext_req_valid,
  output soc_bus_pkg::addr_t               ext_addr,
  output logic                             ext_write,
  output soc_bus_pkg::data_t               ext_wdata,
  output soc_bus_pkg::strb_t               ext_strb,
  input  logic                             ext_req_ready,
  input  logic                             ext_rsp_valid,
  input  soc_bus_pkg::data_t               ext_rdata,
  input  logic                             ext_err
);

  bus_if shared_bus ();
  bus_if l2_bus ();
  bus_if dbg_bus ();
  bus_if ext_bus ();

  bus_arbiter u_arbiter (
    .clk       (clk),
    .arst_n    (arst_n),
    .req_valid (init_req_valid),
    .addr      (init_addr),
    .write     (init_write),
    .wdata     (init_wdata),
    .strb      (init_strb),
    .req_ready (init_req_ready),
    .rsp_valid (init_rsp_valid),
    .rdata     (init_rdata),
    .err       (init_err),
    .bus       (shared_bus.mst)
  );

  addr_decoder u_decoder (
    .clk    (clk),
    .arst_n (arst_n),
    .up     (shared_bus.slv),
    .l2     (l2_bus.mst),
    .dbg    (dbg_bus.mst),
    .ext    (ext_bus.mst)
  );

  l2_mem u_l2 (
    .clk    (clk),
    .arst_n (arst_n),
    .bus    (l2_bus.slv)
  );

  debug_regs u_debug (
    .clk    (clk),
    .arst_n (arst_n),
    .bus    (dbg_bus.slv)
  );

  // external port straight off the decoder
  assign ext_req_valid     = ext_bus.req_valid;
  assign ext_addr          = ext_bus.addr;
  assign ext_write         = ext_bus.write;
  assign ext_wdata         = ext_bus.wdata;
  assign ext_strb          = ext_bus.strb;
  assign ext_bus.req_ready = ext_req_ready;
  assign ext_bus.rsp_valid = ext_rsp_valid;
  assign ext_bus.rdata     = ext_rdata;
  assign ext_bus.err       = ext_err;

endmodule

// File: dv/soc_bus_tb.sv
// soc_bus_tb module: clock, reset, initiator drivers, external target model, reference model, checker
`timescale 1ns/1ps

module soc_bus_tb;
  import soc_bus_pkg::*;

  localparam int    SEED        = 6;
  localparam int    WAIT_CYCLES = 100;       // limit for each handshake wait
  localparam int    WATCHDOG_NS = 500_000;
  localparam data_t EXT_RD_KEY  = 32'hA5A5_A5A5;

  logic              clk;
  logic              arst_n;
  logic [N_INIT-1:0] init_req_valid;
  addr_t             init_addr [N_INIT];
  logic [N_INIT-1:0] init_write;
  data_t             init_wdata [N_INIT];
  strb_t             init_strb [N_INIT];
  logic [N_INIT-1:0] init_req_ready;
  logic [N_INIT-1:0] init_rsp_valid;
  data_t             init_rdata [N_INIT];
  logic [N_INIT-1:0] init_err;
  logic              ext_req_valid;
  addr_t             ext_addr;
  logic              ext_write;
  data_t             ext_wdata;
  strb_t             ext_strb;
  logic              ext_req_ready;
  logic              ext_rsp_valid;
  data_t             ext_rdata;
  logic              ext_err;

  data_t     l2_shadow [L2_WORDS];
  data_t     dbg_shadow [4];
  logic      pend_busy [N_INIT];  // request taken, response still owed
  addr_t     pend_addr [N_INIT];
  logic      pend_write [N_INIT];
  data_t     pend_wdata [N_INIT];
  strb_t     pend_strb [N_INIT];
  init_idx_t done_q [$];          // completion order
  init_idx_t last_grant;
  string     test_name;
  l2_idx_t   widx [8];
  addr_t     arb_addr [N_INIT];
  int        value_errs;
  int        order_errs;
  int        proto_errs;
  int        timeout_errs;

  soc_bus u_soc_bus (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic data_t merge_bytes(data_t old, data_t wd, strb_t st);
    data_t res;
    res = old;
    for (int b = 0; b < DATA_W / 8; b++) begin
      if (st[b]) res[8*b +: 8] = wd[8*b +: 8];
    end
    return res;
  endfunction

  function automatic addr_t l2_addr(l2_idx_t idx);
    return L2_BASE + addr_t'(idx) * 4;
  endfunction

  function automatic addr_t rand_ext_addr();
    return addr_t'($urandom_range(32'hFFFF_FFFF, EXT_BASE)) & ~addr_t'(3);
  endfunction

  // address map rules in priority order
  function automatic tgt_t ref_target(addr_t a);
    if (a >= L2_BASE && a - L2_BASE < L2_BYTES) return TGT_L2;
    if (a >= DEBUG_BASE && a - DEBUG_BASE < DEBUG_BYTES) return TGT_DEBUG;
    if (a >= DEBUG_BASE + DEBUG_BYTES) return TGT_EXT;
    return TGT_NONE;
  endfunction

  function automatic data_t ref_l2(addr_t a, logic wr, data_t wd, strb_t st);
    l2_idx_t idx;
    idx = l2_idx_t'((a - L2_BASE) >> 2);
    if (wr) begin
      l2_shadow[idx] = merge_bytes(l2_shadow[idx], wd, st);
      return '0;
    end
    return l2_shadow[idx];
  endfunction

  function automatic data_t ref_debug(addr_t a, logic wr, data_t wd, strb_t st, output logic e);
    addr_t offs;
    offs = a - DEBUG_BASE;
    e    = 1'b0;
    if (offs < 16 && offs[1:0] == 2'b00) begin
      if (!wr) return dbg_shadow[offs[3:2]];
      dbg_shadow[offs[3:2]] = merge_bytes(dbg_shadow[offs[3:2]], wd, st);
      return '0;
    end
    if (offs == 16) return wr ? '0 : DEBUG_ID; // id ignores writes
    e = 1'b1;
    return '0;
  endfunction

  function automatic data_t ref_ext(addr_t a, logic wr);
    return wr ? '0 : a ^ EXT_RD_KEY;
  endfunction

  function automatic void expect_rsp(addr_t a, logic wr, data_t wd, strb_t st,
                                     output data_t d, output logic e);
    e = 1'b0;
    case (ref_target(a))
      TGT_L2:    d = ref_l2(a, wr, wd, st);
      TGT_DEBUG: d = ref_debug(a, wr, wd, st, e);
      TGT_EXT:   d = ref_ext(a, wr);
      default: begin
        d = '0;
        e = 1'b1; // decode error
      end
    endcase
  endfunction

  task automatic check_data(string name, data_t exp, data_t act);
    if (act !== exp) begin
      value_errs++;
      $display("Error %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_err(string name, logic exp, logic act);
    if (act !== exp) begin
      value_errs++;
      $display("Error %s err: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_addr(string name, addr_t exp, addr_t act);
    if (act !== exp) begin
      value_errs++;
      $display("Error %s addr: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_write(string name, logic exp, logic act);
    if (act !== exp) begin
      value_errs++;
      $display("Error %s write: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_strb(string name, strb_t exp, strb_t act);
    if (act !== exp) begin
      value_errs++;
      $display("Error %s strb: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_idx(string name, init_idx_t exp, init_idx_t act);
    if (act !== exp) begin
      order_errs++;
      $display("Error %s: expected initiator %0d actual %0d", name, exp, act);
    end
  endtask

  // one access from one initiator, request then response
  task automatic run_access(input init_idx_t ini, input addr_t a, input logic wr,
                            input data_t wd, input strb_t st);
    int   cnt;
    logic seen;
    @(posedge clk);
    #1;
    init_req_valid[ini] = 1'b1;
    init_addr[ini]      = a;
    init_write[ini]     = wr;
    init_wdata[ini]     = wd;
    init_strb[ini]      = st;
    cnt = 0;
    @(negedge clk);
    while (!init_req_ready[ini] && cnt < WAIT_CYCLES) begin
      @(negedge clk);
      cnt++;
    end
    seen = init_req_ready[ini];
    @(posedge clk); // transfer edge
    #1;
    init_req_valid[ini] = 1'b0;
    if (!seen) begin
      timeout_errs++;
      $display("initiator %0d was not granted within %0d cycles", ini, WAIT_CYCLES);
    end else begin
      cnt = 0;
      @(negedge clk);
      while (!init_rsp_valid[ini] && cnt < WAIT_CYCLES) begin
        @(negedge clk);
        cnt++;
      end
      if (!init_rsp_valid[ini]) begin
        timeout_errs++;
        $display("initiator %0d got no response within %0d cycles", ini, WAIT_CYCLES);
      end
    end
    @(posedge clk); // checker has logged the response by now
  endtask

  // external target, answers 1 to 5 cycles after the transfer
  initial begin : ext_target_model
    addr_t       cap_addr;
    logic        cap_write;
    int unsigned lat;
    ext_rsp_valid = 1'b0;
    ext_rdata     = '0;
    ext_err       = 1'b0;
    forever begin
      @(negedge clk);
      if (ext_req_valid && ext_req_ready) begin
        cap_addr  = ext_addr;
        cap_write = ext_write;
        lat       = $urandom_range(1, 5);
        repeat (lat) @(posedge clk);
        #1;
        ext_rsp_valid = 1'b1;
        ext_rdata     = cap_write ? '0 : cap_addr ^ EXT_RD_KEY;
        @(posedge clk);
        #1;
        ext_rsp_valid = 1'b0;
        ext_rdata     = '0;
      end
    end
  end

  always @(negedge clk) begin : compare_responses
    data_t exp_d;
    logic  exp_e;
    if (!arst_n) begin
      last_grant = INIT_DEBUG; // so the cluster comes first
      for (int i = 0; i < N_INIT; i++) pend_busy[i] = 1'b0;
      for (int r = 0; r < 4; r++) dbg_shadow[r] = '0;
    end else begin
      if (!ext_req_ready && (init_req_ready != '0 || init_rsp_valid != '0)) begin
        proto_errs++;
        $display("an initiator saw a handshake while the external port stalled");
      end
      if ($countones(init_rsp_valid) > 1) begin
        proto_errs++;
        $display("more than one initiator got a response in the same cycle");
      end
      if (ext_req_valid && ref_target(ext_addr) != TGT_EXT) begin
        proto_errs++;
        $display("external request raised for address %h", ext_addr);
      end
      for (int i = 0; i < N_INIT; i++) begin
        if (init_rsp_valid[i] && !pend_busy[i]) begin
          proto_errs++;
          $display("initiator %0d got a response it did not ask for", i);
        end else if (init_rsp_valid[i]) begin
          expect_rsp(pend_addr[i], pend_write[i], pend_wdata[i], pend_strb[i], exp_d, exp_e);
          check_data(test_name, exp_d, init_rdata[i]);
          check_err(test_name, exp_e, init_err[i]);
          pend_busy[i] = 1'b0;
          last_grant   = init_idx_t'(i);
          done_q.push_back(init_idx_t'(i));
        end
        if (init_req_valid[i] && init_req_ready[i]) begin
          pend_busy[i]  = 1'b1;
          pend_addr[i]  = init_addr[i];
          pend_write[i] = init_write[i];
          pend_wdata[i] = init_wdata[i];
          pend_strb[i]  = init_strb[i];
          if (ext_req_valid) begin // forwarded fields must match the initiator
            check_addr("ext forwarding", init_addr[i], ext_addr);
            check_write("ext forwarding", init_write[i], ext_write);
            check_data("ext forwarding wdata", init_wdata[i], ext_wdata);
            check_strb("ext forwarding", init_strb[i], ext_strb);
          end
        end
      end
    end
  end

  initial begin : run_watchdog
    #(WATCHDOG_NS);
    $display("simulation did not finish within %0d ns", WATCHDOG_NS);
    $display("errors: value %0d, order %0d, protocol %0d, timeout %0d",
             value_errs, order_errs, proto_errs, timeout_errs);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin : main_sequence
    int ini;
    int base;
    int start_ini;
    void'($urandom(SEED));
    arst_n         = 1'b0;
    init_req_valid = '0;
    init_write     = '0;
    ext_req_ready  = 1'b1;
    test_name      = "reset";
    for (int i = 0; i < N_INIT; i++) begin
      init_addr[i]  = '0;
      init_wdata[i] = '0;
      init_strb[i]  = '0;
    end
    repeat (10) @(posedge clk);
    #1;
    arst_n = 1'b1;

    // all three at once, order must rotate
    test_name = "arbitration";
    for (int r = 0; r < 4; r++) begin
      for (int i = 0; i < N_INIT; i++) arb_addr[i] = rand_ext_addr();
      // single access first so each round starts from a different last grant
      if (r > 0) run_access(init_idx_t'(r % N_INIT), rand_ext_addr(), 1'b0, '0, '0);
      base      = done_q.size();
      start_ini = (int'(last_grant) + 1) % N_INIT;
      fork
        run_access(0, arb_addr[0], 1'b0, '0, '0);
        run_access(1, arb_addr[1], 1'b0, '0, '0);
        run_access(2, arb_addr[2], 1'b0, '0, '0);
      join
      for (int k = 0; k < N_INIT; k++) begin
        check_idx("arbitration", init_idx_t'((start_ini + k) % N_INIT), done_q[base + k]);
      end
    end

    test_name = "l2";
    for (int k = 0; k < 8; k++) begin
      widx[k] = l2_idx_t'($urandom_range(0, L2_WORDS - 1));
      run_access(INIT_CLUSTER, l2_addr(widx[k]), 1'b1, $urandom, 4'hF);
    end
    for (int n = 0; n < 12; n++) begin
      ini = int'($urandom_range(0, 7));
      run_access(INIT_HOST, l2_addr(widx[ini]), 1'b1, $urandom, strb_t'($urandom_range(1, 15)));
    end
    for (int k = 0; k < 8; k++) run_access(INIT_DEBUG, l2_addr(widx[k]), 1'b0, '0, '0);

    test_name = "debug";
    for (int r = 0; r < 4; r++) begin
      run_access(INIT_HOST, DEBUG_BASE + addr_t'(4 * r), 1'b1, $urandom,
                 strb_t'($urandom_range(1, 15)));
    end
    for (int r = 0; r < 4; r++) run_access(INIT_CLUSTER, DEBUG_BASE + addr_t'(4 * r), 1'b0, '0, '0);
    run_access(INIT_CLUSTER, DEBUG_BASE + 32'h10, 1'b1, $urandom, 4'hF);
    run_access(INIT_CLUSTER, DEBUG_BASE + 32'h10, 1'b0, '0, '0);
    run_access(INIT_DEBUG, DEBUG_BASE + 32'h40, 1'b0, '0, '0);  // hole in the window
    run_access(INIT_DEBUG, DEBUG_BASE + 32'h14, 1'b1, $urandom, 4'hF);

    test_name = "unmapped";
    run_access(INIT_HOST, 32'h0000_1000, 1'b0, '0, '0);
    run_access(INIT_CLUSTER, 32'h1000_0000, 1'b1, $urandom, 4'hF);

    test_name = "external";
    for (int n = 0; n < 10; n++) begin
      run_access(init_idx_t'($urandom_range(0, 2)), rand_ext_addr(), ($urandom_range(0, 1) == 1),
                 $urandom, strb_t'($urandom_range(0, 15)));
    end

    // next in line goes external and is stalled, the others queue behind it
    test_name   = "backpressure";
    ini         = (int'(last_grant) + 1) % N_INIT;
    arb_addr[0] = rand_ext_addr();
    @(posedge clk);
    #1;
    ext_req_ready = 1'b0;
    fork
      run_access(init_idx_t'(ini), arb_addr[0], 1'b0, '0, '0);
      run_access(init_idx_t'((ini + 1) % N_INIT), l2_addr(widx[0]), 1'b0, '0, '0);
      run_access(init_idx_t'((ini + 2) % N_INIT), DEBUG_BASE + 32'h10, 1'b0, '0, '0);
      begin
        repeat (8) @(posedge clk);
        #1;
        ext_req_ready = 1'b1;
      end
    join

    repeat (5) @(posedge clk);
    $display("errors: value %0d, order %0d, protocol %0d, timeout %0d",
             value_errs, order_errs, proto_errs, timeout_errs);
    if (value_errs + order_errs + proto_errs + timeout_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
design/soc_bus_pkg.sv
design/bus_if.sv
design/bus_arbiter.sv
design/addr_decoder.sv
design/l2_mem.sv
design/debug_regs.sv
design/soc_bus.sv
dv/soc_bus_tb.sv

// File: run.sh
#!/bin/sh
# compile the soc bus testbench with verilator, run it and scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 -f files.f --top-module soc_bus_tb -o soc_bus_sim
./obj_dir/soc_bus_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation run ok"
else
  echo "simulation run reported failure"
  exit 1
fi
